//--- dma_top.f
verilog/dma_pkg.sv
verilog/dma_cmd_table.sv
verilog/dma_cmd_arbiter.sv
verilog/dma_channel.sv
verilog/dma_top.sv
tests/dma_assert.sv
tests/dma_tb.sv

//--- Makefile
# Verilator build and run for the DMA engine testbench

VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= dma_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tests/dma_tb.sv
`timescale 1ns/1ps

module dma_tb;
  import dma_pkg::*;

  localparam int N_CH         = 2;
  localparam int MAX_CREDITS  = 4;
  localparam int HALF_PERIOD  = 50;
  localparam int DONE_TIMEOUT = 2000;
  localparam int DROP_TIMEOUT = 10;

  logic                 clk;
  logic                 rst;
  logic                 i_cmd_we;
  cmd_idx_t             i_cmd_waddr;
  addr_t                i_cmd_src;
  addr_t                i_cmd_dst;
  count_t               i_cmd_count;
  logic                 i_cmd_src_inc;
  logic                 i_cmd_src_dec;
  logic                 i_cmd_dst_inc;
  logic                 i_cmd_dst_dec;
  logic                 i_cmd_cont;
  cmd_idx_t             i_cmd_next;
  logic [N_CH-1:0]      i_ch_enable;
  cmd_idx_t [N_CH-1:0]  i_ch_start_idx;
  logic [N_CH-1:0]      o_src_strobe;
  addr_t [N_CH-1:0]     o_src_addr;
  data_t [N_CH-1:0]     i_src_data;
  logic [N_CH-1:0]      i_snk_credit;
  logic [N_CH-1:0]      o_snk_valid;
  addr_t [N_CH-1:0]     o_snk_addr;
  data_t [N_CH-1:0]     o_snk_data;
  logic [N_CH-1:0]      o_busy;
  logic [N_CH-1:0]      o_done;

  integer seed = 32'h5c1dfc80;
  logic   credit_en;
  int     seq [N_CH];

  dma_top #(
    .N_CH        (N_CH),
    .MAX_CREDITS (MAX_CREDITS)
  ) DUT (.*);

  bind dma_top dma_assert #(.N_CH(N_CH), .MAX_CREDITS(MAX_CREDITS)) u_chk (.*);

  always #HALF_PERIOD clk = ~clk;

  // Channel number in the top byte, running count below
  function automatic data_t source_word(int ch, int n);
    return {ch[7:0], n[23:0]};
  endfunction

  // FIFO-like source, head word is always presented
  always @(posedge clk) begin
    for (int c = 0; c < N_CH; c++) begin
      if (rst) begin
        seq[c]        <= 0;
        i_src_data[c] <= source_word(c, 0);
      end else if (o_src_strobe[c]) begin
        seq[c]        <= seq[c] + 1;
        i_src_data[c] <= source_word(c, seq[c] + 1);
      end
    end
  end

  // Random credits, roughly three cycles in four
  always @(posedge clk) begin
    logic [31:0] draw;
    for (int c = 0; c < N_CH; c++) begin
      draw = $random(seed);
      i_snk_credit[c] <= !rst && credit_en && (draw[1:0] != 2'b00);
    end
  end

  always @(negedge clk) begin
    if (DUT.u_chk.fail_total != 0) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "An assertion in dma_assert failed");
    end
  end

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", why);
  endtask

  // flags: src_inc, src_dec, dst_inc, dst_dec, cont
  task automatic write_cmd(input cmd_idx_t idx, input addr_t src, input addr_t dst,
                           input count_t count, input logic [4:0] flags,
                           input cmd_idx_t next);
    @(posedge clk);
    i_cmd_we      <= 1'b1;
    i_cmd_waddr   <= idx;
    i_cmd_src     <= src;
    i_cmd_dst     <= dst;
    i_cmd_count   <= count;
    i_cmd_src_inc <= flags[4];
    i_cmd_src_dec <= flags[3];
    i_cmd_dst_inc <= flags[2];
    i_cmd_dst_dec <= flags[1];
    i_cmd_cont    <= flags[0];
    i_cmd_next    <= next;
  endtask

  task automatic wait_for_done(input int ch, input logic level, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (o_done[ch] != level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (o_done[ch] != level) begin
      abort_run($sformatf("o_done of channel %0d did not go to %0b", ch, level));
    end
  endtask

  initial begin
    clk            = 1'b0;
    rst            <= 1'b1;
    i_cmd_we       <= 1'b0;
    i_cmd_waddr    <= '0;
    i_cmd_src      <= '0;
    i_cmd_dst      <= '0;
    i_cmd_count    <= '0;
    i_cmd_src_inc  <= 1'b0;
    i_cmd_src_dec  <= 1'b0;
    i_cmd_dst_inc  <= 1'b0;
    i_cmd_dst_dec  <= 1'b0;
    i_cmd_cont     <= 1'b0;
    i_cmd_next     <= '0;
    i_ch_enable    <= '0;
    i_ch_start_idx <= '0;
    i_snk_credit   <= '0;
    credit_en      <= 1'b0;
    for (int c = 0; c < N_CH; c++) begin
      i_src_data[c] <= source_word(c, 0);
    end

    repeat (2) @(posedge clk);
    rst       <= 1'b0;
    credit_en <= 1'b1;

    // Channel 0 chain 0 -> 3, channel 1 runs 5 alone
    write_cmd(3'd0, 32'h0000_1000, 32'h0000_8000, 16'd6, 5'b10101, 3'd3);
    write_cmd(3'd3, 32'h0000_2000, 32'h0000_9000, 16'd5, 5'b00110, 3'd0);
    write_cmd(3'd5, 32'h0000_3000, 32'h0000_a010, 16'd8, 5'b01010, 3'd0);
    @(posedge clk);
    i_cmd_we <= 1'b0;

    // Idle credits pile up before the start
    repeat (8) @(posedge clk);
    i_ch_start_idx[0] <= 3'd0;
    i_ch_start_idx[1] <= 3'd5;
    i_ch_enable       <= '1;

    // Credit stall in the middle of the run
    repeat (10) @(posedge clk);
    credit_en <= 1'b0;
    repeat (12) @(posedge clk);
    credit_en <= 1'b1;

    wait_for_done(0, 1'b1, DONE_TIMEOUT);
    wait_for_done(1, 1'b1, DONE_TIMEOUT);
    repeat (3) @(posedge clk);
    i_ch_enable <= '0;
    wait_for_done(0, 1'b0, DROP_TIMEOUT);
    wait_for_done(1, 1'b0, DROP_TIMEOUT);
    repeat (2) @(negedge clk);

    if (DUT.u_chk.fail_total == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "Assertion failures counted at the end of the run");
    end
  end

endmodule

//--- tests/dma_assert.sv
`timescale 1ns/1ps

module dma_assert #(
  parameter int N_CH        = 2,
  parameter int MAX_CREDITS = 4
) (
  input logic                         clk,
  input logic                         rst,
  input logic                         i_cmd_we,
  input dma_pkg::cmd_idx_t            i_cmd_waddr,
  input dma_pkg::addr_t               i_cmd_src,
  input dma_pkg::addr_t               i_cmd_dst,
  input dma_pkg::count_t              i_cmd_count,
  input logic                         i_cmd_src_inc,
  input logic                         i_cmd_src_dec,
  input logic                         i_cmd_dst_inc,
  input logic                         i_cmd_dst_dec,
  input logic                         i_cmd_cont,
  input dma_pkg::cmd_idx_t            i_cmd_next,
  input logic [N_CH-1:0]              i_ch_enable,
  input dma_pkg::cmd_idx_t [N_CH-1:0] i_ch_start_idx,
  input logic [N_CH-1:0]              o_src_strobe,
  input dma_pkg::addr_t [N_CH-1:0]    o_src_addr,
  input logic [N_CH-1:0]              i_snk_credit,
  input logic [N_CH-1:0]              o_snk_valid,
  input dma_pkg::addr_t [N_CH-1:0]    o_snk_addr,
  input dma_pkg::data_t [N_CH-1:0]    o_snk_data,
  input logic [N_CH-1:0]              o_busy,
  input logic [N_CH-1:0]              o_done
);
  import dma_pkg::*;

  // Shadow of the command table
  addr_t      sh_src   [CMD_DEPTH];
  addr_t      sh_dst   [CMD_DEPTH];
  count_t     sh_count [CMD_DEPTH];
  // src_inc, src_dec, dst_inc, dst_dec, cont
  logic [4:0] sh_flag  [CMD_DEPTH];
  cmd_idx_t   sh_next  [CMD_DEPTH];

  logic [N_CH-1:0] en_q;
  logic [N_CH-1:0] en_seen_q;
  int              credit_cnt  [N_CH];
  int              strobe_cnt  [N_CH];
  int              write_cnt   [N_CH];
  int              run_writes  [N_CH];
  int              chain_total [N_CH];

  // Expected position in the chain, source side and sink side
  cmd_idx_t s_cmd  [N_CH];
  addr_t    s_addr [N_CH];
  count_t   s_left [N_CH];
  cmd_idx_t d_cmd  [N_CH];
  addr_t    d_addr [N_CH];
  count_t   d_left [N_CH];

  int fail_cnt [N_CH];
  int fail_total;

  function automatic addr_t step_addr(addr_t a, logic inc, logic dec);
    if (inc) begin
      return a + addr_t'(1);
    end else if (dec) begin
      return a - addr_t'(1);
    end
    return a;
  endfunction

  function automatic int chain_words(cmd_idx_t start);
    int       total;
    cmd_idx_t idx;
    logic     more;
    total = 0;
    idx   = start;
    more  = 1'b1;
    for (int k = 0; k < CMD_DEPTH; k++) begin
      if (more) begin
        total += int'(sh_count[idx]);
        more   = sh_flag[idx][0];
        idx    = sh_next[idx];
      end
    end
    return total;
  endfunction

  // Same word layout as the source model
  function automatic data_t expected_word(int ch, int n);
    return {ch[7:0], n[23:0]};
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < CMD_DEPTH; i++) begin
        sh_src[i]   <= '0;
        sh_dst[i]   <= '0;
        sh_count[i] <= '0;
        sh_flag[i]  <= '0;
        sh_next[i]  <= '0;
      end
    end else if (i_cmd_we) begin
      sh_src[i_cmd_waddr]   <= i_cmd_src;
      sh_dst[i_cmd_waddr]   <= i_cmd_dst;
      sh_count[i_cmd_waddr] <= i_cmd_count;
      sh_flag[i_cmd_waddr]  <= {i_cmd_src_inc, i_cmd_src_dec, i_cmd_dst_inc,
                                i_cmd_dst_dec, i_cmd_cont};
      sh_next[i_cmd_waddr]  <= i_cmd_next;
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < N_CH; c++) begin
      if (rst) begin
        en_q[c]       <= 1'b0;
        en_seen_q[c]  <= 1'b0;
        credit_cnt[c] <= 0;
        strobe_cnt[c] <= 0;
        write_cnt[c]  <= 0;
        run_writes[c] <= 0;
      end else begin
        en_q[c] <= i_ch_enable[c];
        if (i_ch_enable[c]) begin
          en_seen_q[c] <= 1'b1;
        end
        // A credit past MAX_CREDITS held is dropped
        if (i_snk_credit[c] &&
            credit_cnt[c] - strobe_cnt[c] - int'(o_src_strobe[c]) < MAX_CREDITS) begin
          credit_cnt[c] <= credit_cnt[c] + 1;
        end
        if (o_src_strobe[c]) begin
          strobe_cnt[c] <= strobe_cnt[c] + 1;
          if (s_left[c] == count_t'(1) && sh_flag[s_cmd[c]][0]) begin
            s_cmd[c]  <= sh_next[s_cmd[c]];
            s_addr[c] <= sh_src[sh_next[s_cmd[c]]];
            s_left[c] <= sh_count[sh_next[s_cmd[c]]];
          end else begin
            s_addr[c] <= step_addr(s_addr[c], sh_flag[s_cmd[c]][4], sh_flag[s_cmd[c]][3]);
            s_left[c] <= s_left[c] - count_t'(1);
          end
        end
        if (o_snk_valid[c]) begin
          write_cnt[c]  <= write_cnt[c] + 1;
          run_writes[c] <= run_writes[c] + 1;
          if (d_left[c] == count_t'(1) && sh_flag[d_cmd[c]][0]) begin
            d_cmd[c]  <= sh_next[d_cmd[c]];
            d_addr[c] <= sh_dst[sh_next[d_cmd[c]]];
            d_left[c] <= sh_count[sh_next[d_cmd[c]]];
          end else begin
            d_addr[c] <= step_addr(d_addr[c], sh_flag[d_cmd[c]][2], sh_flag[d_cmd[c]][1]);
            d_left[c] <= d_left[c] - count_t'(1);
          end
        end
        // New run starts at the head of the chain
        if (i_ch_enable[c] && !en_q[c]) begin
          run_writes[c]  <= 0;
          chain_total[c] <= chain_words(i_ch_start_idx[c]);
          s_cmd[c]       <= i_ch_start_idx[c];
          s_addr[c]      <= sh_src[i_ch_start_idx[c]];
          s_left[c]      <= sh_count[i_ch_start_idx[c]];
          d_cmd[c]       <= i_ch_start_idx[c];
          d_addr[c]      <= sh_dst[i_ch_start_idx[c]];
          d_left[c]      <= sh_count[i_ch_start_idx[c]];
        end
      end
    end
  end

  always_comb begin
    fail_total = 0;
    for (int i = 0; i < N_CH; i++) begin
      fail_total += fail_cnt[i];
    end
  end

  for (genvar c = 0; c < N_CH; c++) begin : g_chk
    a_quiet: assert property (@(posedge clk) disable iff (rst)
      !(en_seen_q[c] || i_ch_enable[c]) |->
        !(o_src_strobe[c] || o_snk_valid[c] || o_busy[c] || o_done[c]))
    else begin
      $error("Channel %0d left idle before its first enable", c);
      fail_cnt[c]++;
    end

    a_credit: assert property (@(posedge clk) disable iff (rst)
      o_src_strobe[c] |-> strobe_cnt[c] < credit_cnt[c])
    else begin
      $error("[ERROR] strobe_cnt[%0d] = %h with credit_cnt = %h", c,
             $sampled(strobe_cnt[c]), $sampled(credit_cnt[c]));
      fail_cnt[c]++;
    end

    a_write_follows: assert property (@(posedge clk) disable iff (rst)
      o_src_strobe[c] |=> o_snk_valid[c])
    else begin
      $error("Channel %0d strobe not followed by a sink write", c);
      fail_cnt[c]++;
    end

    a_write_source: assert property (@(posedge clk) disable iff (rst)
      o_snk_valid[c] |-> $past(o_src_strobe[c]))
    else begin
      $error("Channel %0d sink write without a strobe one cycle earlier", c);
      fail_cnt[c]++;
    end

    a_data: assert property (@(posedge clk) disable iff (rst)
      o_snk_valid[c] |-> o_snk_data[c] == expected_word(c, write_cnt[c]))
    else begin
      $error("[ERROR] o_snk_data[%0d] = %h, expected %h", c, $sampled(o_snk_data[c]),
             expected_word(c, $sampled(write_cnt[c])));
      fail_cnt[c]++;
    end

    a_src_addr: assert property (@(posedge clk) disable iff (rst)
      o_src_strobe[c] |-> o_src_addr[c] == s_addr[c])
    else begin
      $error("[ERROR] o_src_addr[%0d] = %h, expected %h", c, $sampled(o_src_addr[c]),
             $sampled(s_addr[c]));
      fail_cnt[c]++;
    end

    a_dst_addr: assert property (@(posedge clk) disable iff (rst)
      o_snk_valid[c] |-> o_snk_addr[c] == d_addr[c])
    else begin
      $error("[ERROR] o_snk_addr[%0d] = %h, expected %h", c, $sampled(o_snk_addr[c]),
             $sampled(d_addr[c]));
      fail_cnt[c]++;
    end

    a_chain: assert property (@(posedge clk) disable iff (rst)
      $rose(o_done[c]) |-> run_writes[c] == chain_total[c])
    else begin
      $error("[ERROR] writes before o_done[%0d] = %h, expected %h", c,
             $sampled(run_writes[c]), $sampled(chain_total[c]));
      fail_cnt[c]++;
    end

    // Done holds with the enable and clears one cycle after it drops
    a_done: assert property (@(posedge clk) disable iff (rst)
      o_done[c] |=> o_done[c] == $past(i_ch_enable[c]))
    else begin
      $error("Channel %0d o_done did not follow the enable", c);
      fail_cnt[c]++;
    end
  end

endmodule

//--- verilog/dma_top.sv
`timescale 1ns/1ps

module dma_top #(
  parameter int N_CH        = 2,
  parameter int MAX_CREDITS = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         i_cmd_we,
  input  dma_pkg::cmd_idx_t            i_cmd_waddr,
  input  dma_pkg::addr_t               i_cmd_src,
  input  dma_pkg::addr_t               i_cmd_dst,
  input  dma_pkg::count_t              i_cmd_count,
  input  logic                         i_cmd_src_inc,
  input  logic                         i_cmd_src_dec,
  input  logic                         i_cmd_dst_inc,
  input  logic                         i_cmd_dst_dec,
  input  logic                         i_cmd_cont,
  input  dma_pkg::cmd_idx_t            i_cmd_next,
  input  logic [N_CH-1:0]              i_ch_enable,
  input  dma_pkg::cmd_idx_t [N_CH-1:0] i_ch_start_idx,
  output logic [N_CH-1:0]              o_src_strobe,
  output dma_pkg::addr_t [N_CH-1:0]    o_src_addr,
  input  dma_pkg::data_t [N_CH-1:0]    i_src_data,
  input  logic [N_CH-1:0]              i_snk_credit,
  output logic [N_CH-1:0]              o_snk_valid,
  output dma_pkg::addr_t [N_CH-1:0]    o_snk_addr,
  output dma_pkg::data_t [N_CH-1:0]    o_snk_data,
  output logic [N_CH-1:0]              o_busy,
  output logic [N_CH-1:0]              o_done
);
  import dma_pkg::*;

  logic [N_CH-1:0]           fetch_req;
  cmd_idx_t [N_CH-1:0]       fetch_idx;
  logic [N_CH-1:0]           fetch_gnt;
  logic [N_CH-1:0]           fetch_valid;
  cmd_idx_t                  tbl_raddr;

  // Table read data, shared by all channels
  addr_t    tbl_src;
  addr_t    tbl_dst;
  count_t   tbl_count;
  logic     tbl_src_inc;
  logic     tbl_src_dec;
  logic     tbl_dst_inc;
  logic     tbl_dst_dec;
  logic     tbl_cont;
  cmd_idx_t tbl_next;

  dma_cmd_table u_table (
    .clk       (clk),
    .rst       (rst),
    .i_we      (i_cmd_we),
    .i_waddr   (i_cmd_waddr),
    .i_src     (i_cmd_src),
    .i_dst     (i_cmd_dst),
    .i_count   (i_cmd_count),
    .i_src_inc (i_cmd_src_inc),
    .i_src_dec (i_cmd_src_dec),
    .i_dst_inc (i_cmd_dst_inc),
    .i_dst_dec (i_cmd_dst_dec),
    .i_cont    (i_cmd_cont),
    .i_next    (i_cmd_next),
    .i_raddr   (tbl_raddr),
    .o_src     (tbl_src),
    .o_dst     (tbl_dst),
    .o_count   (tbl_count),
    .o_src_inc (tbl_src_inc),
    .o_src_dec (tbl_src_dec),
    .o_dst_inc (tbl_dst_inc),
    .o_dst_dec (tbl_dst_dec),
    .o_cont    (tbl_cont),
    .o_next    (tbl_next)
  );

  dma_cmd_arbiter #(
    .N_CH (N_CH)
  ) u_arbiter (
    .clk     (clk),
    .rst     (rst),
    .i_req   (fetch_req),
    .i_idx   (fetch_idx),
    .o_gnt   (fetch_gnt),
    .o_valid (fetch_valid),
    .o_raddr (tbl_raddr)
  );

  for (genvar c = 0; c < N_CH; c++) begin : g_ch
    dma_channel #(
      .MAX_CREDITS (MAX_CREDITS)
    ) u_channel (
      .clk           (clk),
      .rst           (rst),
      .i_enable      (i_ch_enable[c]),
      .i_start_idx   (i_ch_start_idx[c]),
      .o_fetch_req   (fetch_req[c]),
      .o_fetch_idx   (fetch_idx[c]),
      .i_fetch_gnt   (fetch_gnt[c]),
      .i_fetch_valid (fetch_valid[c]),
      .i_cmd_src     (tbl_src),
      .i_cmd_dst     (tbl_dst),
      .i_cmd_count   (tbl_count),
      .i_cmd_src_inc (tbl_src_inc),
      .i_cmd_src_dec (tbl_src_dec),
      .i_cmd_dst_inc (tbl_dst_inc),
      .i_cmd_dst_dec (tbl_dst_dec),
      .i_cmd_cont    (tbl_cont),
      .i_cmd_next    (tbl_next),
      .o_src_strobe  (o_src_strobe[c]),
      .o_src_addr    (o_src_addr[c]),
      .i_src_data    (i_src_data[c]),
      .i_snk_credit  (i_snk_credit[c]),
      .o_snk_valid   (o_snk_valid[c]),
      .o_snk_addr    (o_snk_addr[c]),
      .o_snk_data    (o_snk_data[c]),
      .o_busy        (o_busy[c]),
      .o_done        (o_done[c])
    );
  end

endmodule

//--- verilog/dma_channel.sv
`timescale 1ns/1ps

module dma_channel #(
  parameter int MAX_CREDITS = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_enable,
  input  dma_pkg::cmd_idx_t i_start_idx,
  output logic              o_fetch_req,
  output dma_pkg::cmd_idx_t o_fetch_idx,
  input  logic              i_fetch_gnt,
  input  logic              i_fetch_valid,
  input  dma_pkg::addr_t    i_cmd_src,
  input  dma_pkg::addr_t    i_cmd_dst,
  input  dma_pkg::count_t   i_cmd_count,
  input  logic              i_cmd_src_inc,
  input  logic              i_cmd_src_dec,
  input  logic              i_cmd_dst_inc,
  input  logic              i_cmd_dst_dec,
  input  logic              i_cmd_cont,
  input  dma_pkg::cmd_idx_t i_cmd_next,
  output logic              o_src_strobe,
  output dma_pkg::addr_t    o_src_addr,
  input  dma_pkg::data_t    i_src_data,
  input  logic              i_snk_credit,
  output logic              o_snk_valid,
  output dma_pkg::addr_t    o_snk_addr,
  output dma_pkg::data_t    o_snk_data,
  output logic              o_busy,
  output logic              o_done
);
  import dma_pkg::*;

  localparam int CRED_W = $clog2(MAX_CREDITS + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(MAX_CREDITS);

  chan_state_t state;
  cmd_idx_t    cmd_idx;
  count_t      remaining;
  logic        stop;

  // Working copy of the current command
  addr_t    src_addr;
  addr_t    dst_addr;
  logic     src_inc;
  logic     src_dec;
  logic     dst_inc;
  logic     dst_dec;
  logic     cont;
  cmd_idx_t next_idx;

  logic [CRED_W-1:0] credits;
  logic              credit_take;
  logic              strobe;

  function automatic addr_t step(addr_t addr, logic inc, logic dec);
    if (inc) begin
      return addr + 1'b1;
    end else if (dec) begin
      return addr - 1'b1;
    end
    return addr;
  endfunction

  assign strobe = (state == ACTIVE) && (credits != '0) && (remaining != '0);

  // A full counter still accepts a credit when a strobe spends one
  assign credit_take = i_snk_credit && ((credits != CRED_MAX) || strobe);

  assign o_src_strobe = strobe;
  assign o_src_addr   = src_addr;
  assign o_fetch_req  = (state == FETCH);
  assign o_fetch_idx  = cmd_idx;
  assign o_busy       = (state != IDLE);
  assign o_done       = (state == FINISHED);

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= '0;
    end else begin
      case ({credit_take, strobe})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      cmd_idx   <= '0;
      remaining <= '0;
      stop      <= 1'b0;
    end else begin
      // Enable loss ends the chain after the current command
      if (!i_enable && state != IDLE) begin
        stop <= 1'b1;
      end
      case (state)
        IDLE: begin
          stop <= 1'b0;
          if (i_enable) begin
            cmd_idx <= i_start_idx;
            state   <= FETCH;
          end
        end
        FETCH: begin
          if (i_fetch_gnt) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          if (i_fetch_valid) begin
            remaining <= i_cmd_count;
            state     <= ACTIVE;
          end
        end
        ACTIVE: begin
          if (strobe) begin
            remaining <= remaining - 1'b1;
          end
          // Last write leaves on the cycle after remaining hits zero
          if (remaining == '0) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (cont && !stop && i_enable) begin
            cmd_idx <= next_idx;
            state   <= FETCH;
          end else begin
            state <= FINISHED;
          end
        end
        FINISHED: begin
          if (!i_enable) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address generators and command fields
  always_ff @(posedge clk) begin
    if (state == LOAD && i_fetch_valid) begin
      src_addr <= i_cmd_src;
      dst_addr <= i_cmd_dst;
      src_inc  <= i_cmd_src_inc;
      src_dec  <= i_cmd_src_dec;
      dst_inc  <= i_cmd_dst_inc;
      dst_dec  <= i_cmd_dst_dec;
      cont     <= i_cmd_cont;
      next_idx <= i_cmd_next;
    end else if (strobe) begin
      src_addr <= step(src_addr, src_inc, src_dec);
      dst_addr <= step(dst_addr, dst_inc, dst_dec);
    end
  end

  // Sink write one cycle behind the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      o_snk_valid <= 1'b0;
    end else begin
      o_snk_valid <= strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (strobe) begin
      o_snk_data <= i_src_data;
      o_snk_addr <= dst_addr;
    end
  end

endmodule

//--- verilog/dma_cmd_arbiter.sv
`timescale 1ns/1ps

module dma_cmd_arbiter #(
  parameter int N_CH = 2
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [N_CH-1:0]              i_req,
  input  dma_pkg::cmd_idx_t [N_CH-1:0] i_idx,
  output logic [N_CH-1:0]              o_gnt,
  output logic [N_CH-1:0]              o_valid,
  output dma_pkg::cmd_idx_t            o_raddr
);

  localparam int PTR_W = (N_CH > 1) ? $clog2(N_CH) : 1;

  // Highest priority requester this cycle
  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] winner;
  logic             found;

  always_comb begin
    int cand;
    found  = 1'b0;
    winner = '0;
    for (int k = 0; k < N_CH; k++) begin
      cand = (int'(ptr) + k) % N_CH;
      if (!found && i_req[cand]) begin
        found  = 1'b1;
        winner = PTR_W'(cand);
      end
    end
  end

  assign o_gnt   = found ? (N_CH'(1) << winner) : '0;
  assign o_raddr = i_idx[winner];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (found) begin
      // Winner drops to lowest priority
      if (winner == PTR_W'(N_CH - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= winner + 1'b1;
      end
    end
  end

  // Table read is registered, so valid trails the grant by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= '0;
    end else begin
      o_valid <= o_gnt;
    end
  end

endmodule

//--- verilog/dma_cmd_table.sv
`timescale 1ns/1ps

module dma_cmd_table (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_we,
  input  dma_pkg::cmd_idx_t i_waddr,
  input  dma_pkg::addr_t    i_src,
  input  dma_pkg::addr_t    i_dst,
  input  dma_pkg::count_t   i_count,
  input  logic              i_src_inc,
  input  logic              i_src_dec,
  input  logic              i_dst_inc,
  input  logic              i_dst_dec,
  input  logic              i_cont,
  input  dma_pkg::cmd_idx_t i_next,
  input  dma_pkg::cmd_idx_t i_raddr,
  output dma_pkg::addr_t    o_src,
  output dma_pkg::addr_t    o_dst,
  output dma_pkg::count_t   o_count,
  output logic              o_src_inc,
  output logic              o_src_dec,
  output logic              o_dst_inc,
  output logic              o_dst_dec,
  output logic              o_cont,
  output dma_pkg::cmd_idx_t o_next
);
  import dma_pkg::*;

  addr_t    src_mem   [CMD_DEPTH];
  addr_t    dst_mem   [CMD_DEPTH];
  count_t   count_mem [CMD_DEPTH];
  // src_inc, src_dec, dst_inc, dst_dec, cont
  logic [4:0] flag_mem [CMD_DEPTH];
  cmd_idx_t next_mem  [CMD_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < CMD_DEPTH; i++) begin
        src_mem[i]   <= '0;
        dst_mem[i]   <= '0;
        count_mem[i] <= '0;
        flag_mem[i]  <= '0;
        next_mem[i]  <= '0;
      end
    end else if (i_we) begin
      src_mem[i_waddr]   <= i_src;
      dst_mem[i_waddr]   <= i_dst;
      count_mem[i_waddr] <= i_count;
      flag_mem[i_waddr]  <= {i_src_inc, i_src_dec, i_dst_inc, i_dst_dec, i_cont};
      next_mem[i_waddr]  <= i_next;
    end
  end

  // Registered read, data lines up with the arbiter's valid
  always_ff @(posedge clk) begin
    o_src   <= src_mem[i_raddr];
    o_dst   <= dst_mem[i_raddr];
    o_count <= count_mem[i_raddr];
    {o_src_inc, o_src_dec, o_dst_inc, o_dst_dec, o_cont} <= flag_mem[i_raddr];
    o_next  <= next_mem[i_raddr];
  end

endmodule

//--- verilog/dma_pkg.sv
package dma_pkg;

  // Bus widths
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int COUNT_W = 16;

  // Command table geometry
  localparam int CMD_DEPTH = 8;
  localparam int CMD_IDX_W = 3;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [COUNT_W-1:0]   count_t;
  typedef logic [CMD_IDX_W-1:0] cmd_idx_t;

  // Channel FSM
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    FETCH    = 3'd1,
    LOAD     = 3'd2,
    ACTIVE   = 3'd3,
    DRAIN    = 3'd4,
    FINISHED = 3'd5
  } chan_state_t;

endpackage
